//--- design/div_config.svh
// ----------------------------------------
// Divide unit configuration
// word width and loop length
// ----------------------------------------

`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// operand and result width
`define DIV_XLEN 32

// one quotient bit per iteration
`define DIV_ITERS `DIV_XLEN

`define DIV_CNT_W 6 // must hold DIV_ITERS

`endif

//--- design/div_op_pkg.sv
// ----------------------------------------
// Divide operation types
// funct3 opcodes and the data word
// ----------------------------------------

`default_nettype none

`include "div_config.svh"

package div_op_pkg;

    typedef logic [`DIV_XLEN-1:0] div_word_t;

    // M-extension funct3 codes
    typedef enum logic [2:0] {
        OP_DIV  = 3'd4,
        OP_DIVU = 3'd5,
        OP_REM  = 3'd6,
        OP_REMU = 3'd7
    } div_op_e;

endpackage

`default_nettype wire

//--- design/div_ctrl_pkg.sv
// ----------------------------------------
// Divide controller types
// ----------------------------------------

`default_nettype none

package div_ctrl_pkg;

    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,
        S_SETUP  = 2'd1, // magnitudes and invert flag
        S_CALC   = 2'd2, // shift-subtract loop
        S_FINISH = 2'd3
    } div_state_e;

endpackage

`default_nettype wire

//--- design/div_step_if.sv
// ----------------------------------------
// Divide step bus
// strobes from the controller, divisor
// status back from the datapath
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface div_step_if;

    logic capture; // latch operands and op
    logic setup;   // magnitudes, remainder load
    logic step;    // one shift-subtract
    logic finish;  // write result

    logic divisor_zero;

    modport ctrl (
        output capture,
        output setup,
        output step,
        output finish,
        input  divisor_zero
    );

    modport dp (
        input  capture,
        input  setup,
        input  step,
        input  finish,
        output divisor_zero
    );

endinterface

`default_nettype wire

//--- design/div_iter_counter.sv
// ----------------------------------------
// Divide iteration counter
// counts down the remaining quotient bits
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_iter_counter (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  load_i,
    input  wire  dec_i,
    output logic last_o
);

    logic [`DIV_CNT_W-1:0] count_q;

    // load wins over decrement
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= `DIV_CNT_W'(`DIV_ITERS);
        end else if (dec_i && (count_q != '0)) begin
            count_q <= count_q - 1'b1;
        end
    end

    // final step is the one taken at count 1
    assign last_o = (count_q == `DIV_CNT_W'd1);

endmodule

`default_nettype wire

//--- design/div_datapath.sv
// ----------------------------------------
// Divide datapath
// restoring shift-subtract with sign
// fix-up before and after the loop
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_datapath (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire div_op_pkg::div_word_t dividend_i,
    input  wire div_op_pkg::div_word_t divisor_i,
    input  wire div_op_pkg::div_op_e   op_i,
    output div_op_pkg::div_word_t      result_o,
    div_step_if.dp                     step_bus
);

    import div_op_pkg::*;

    div_op_e   op_q;
    div_word_t dividend_q; // as captured
    div_word_t divisor_q;
    div_word_t shift_q;    // dividend magnitude, shifted out msb first
    div_word_t dvsr_q;     // divisor magnitude
    div_word_t rem_q;      // partial remainder
    div_word_t quo_q;
    logic      invert_q;

    logic      signed_op;
    logic      is_div_op;
    logic      dividend_neg;
    logic      divisor_neg;
    div_word_t dividend_mag;
    div_word_t divisor_mag;

    logic [`DIV_XLEN:0] trial;
    logic [`DIV_XLEN:0] trial_diff;
    logic               trial_ge;
    div_word_t          trial_rem;

    div_word_t raw_res;
    div_word_t final_res;

    assign signed_op = (op_q == OP_DIV) || (op_q == OP_REM);
    assign is_div_op = (op_q == OP_DIV) || (op_q == OP_DIVU);

    // sign pre-processing
    assign dividend_neg = signed_op && dividend_q[`DIV_XLEN-1];
    assign divisor_neg  = signed_op && divisor_q[`DIV_XLEN-1];
    assign dividend_mag = dividend_neg ? -dividend_q : dividend_q;
    assign divisor_mag  = divisor_neg ? -divisor_q : divisor_q;

    assign step_bus.divisor_zero = (divisor_q == '0);

    // bring in the next dividend bit, then try the subtract
    assign trial      = {rem_q, shift_q[`DIV_XLEN-1]};
    assign trial_diff = trial - {1'b0, dvsr_q};
    assign trial_ge   = (trial >= {1'b0, dvsr_q});
    assign trial_rem  = trial_ge ? trial_diff[`DIV_XLEN-1:0] : trial[`DIV_XLEN-1:0];

    always_ff @(posedge clk) begin
        if (step_bus.capture) begin
            op_q       <= op_i;
            dividend_q <= dividend_i;
            divisor_q  <= divisor_i;
        end else if (step_bus.setup) begin
            shift_q <= dividend_mag;
            dvsr_q  <= divisor_mag;
            rem_q   <= '0;
            quo_q   <= '0;
            // quotient sign from both operands, remainder follows dividend
            invert_q <= ((op_q == OP_DIV) && (dividend_neg ^ divisor_neg))
                     || ((op_q == OP_REM) && dividend_neg);
        end else if (step_bus.step) begin
            shift_q <= shift_q << 1;
            rem_q   <= trial_rem;
            quo_q   <= {quo_q[`DIV_XLEN-2:0], trial_ge};
        end
    end

    // sign post-processing
    assign raw_res = is_div_op ? quo_q : rem_q;

    always_comb begin
        if (step_bus.divisor_zero) begin
            final_res = is_div_op ? '1 : dividend_q; // zero divisor rule
        end else if (invert_q) begin
            final_res = -raw_res;
        end else begin
            final_res = raw_res;
        end
    end

    // result holds until the next finish
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_o <= '0;
        end else if (step_bus.finish) begin
            result_o <= final_res;
        end
    end

endmodule

`default_nettype wire

//--- design/div_control.sv
// ----------------------------------------
// Divide controller
// sequences capture, setup, loop, finish
// and owns busy and the ready pulse
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module div_control (
    input  wire      clk,
    input  wire      rst_n,
    input  wire      start_i,
    output logic     busy_o,
    output logic     ready_o,
    output logic     cnt_load_o,
    output logic     cnt_dec_o,
    input  wire      cnt_last_i,
    div_step_if.ctrl step_bus
);

    import div_ctrl_pkg::*;

    div_state_e state_q;
    div_state_e state_d;

    logic do_capture;
    logic do_setup;
    logic do_step;
    logic do_finish;

    // every strobe needs start_i still held
    always_comb begin
        state_d    = state_q;
        do_capture = 1'b0;
        do_setup   = 1'b0;
        do_step    = 1'b0;
        do_finish  = 1'b0;
        cnt_load_o = 1'b0;

        if (!start_i) begin
            state_d = S_IDLE; // abort, or stay idle
        end else begin
            case (state_q)
                S_IDLE: begin
                    do_capture = 1'b1;
                    state_d    = S_SETUP;
                end
                S_SETUP: begin
                    do_setup = 1'b1;
                    if (step_bus.divisor_zero) begin
                        state_d = S_FINISH; // skip the loop
                    end else begin
                        cnt_load_o = 1'b1;
                        state_d    = S_CALC;
                    end
                end
                S_CALC: begin
                    do_step = 1'b1;
                    if (cnt_last_i) begin
                        state_d = S_FINISH;
                    end
                end
                S_FINISH: begin
                    do_finish = 1'b1;
                    state_d   = S_IDLE;
                end
                default: begin
                    state_d = S_IDLE;
                end
            endcase
        end
    end

    assign cnt_dec_o = do_step;

    assign step_bus.capture = do_capture;
    assign step_bus.setup   = do_setup;
    assign step_bus.step    = do_step;
    assign step_bus.finish  = do_finish;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            busy_o  <= 1'b0;
            ready_o <= 1'b0;
        end else begin
            state_q <= state_d;
            busy_o  <= (state_d != S_IDLE); // drops on finish or abort
            ready_o <= do_finish;           // single cycle pulse
        end
    end

endmodule

`default_nettype wire

//--- design/div_unit.sv
// ----------------------------------------
// Iterative integer divide unit
// DIV, DIVU, REM, REMU in 34 cycles
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module div_unit (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        start_i,  // held for the whole op
    input  wire div_op_pkg::div_op_e   op_i,
    input  wire div_op_pkg::div_word_t dividend_i,
    input  wire div_op_pkg::div_word_t divisor_i,
    output div_op_pkg::div_word_t      result_o,
    output logic                       ready_o,  // one cycle pulse
    output logic                       busy_o
);

    logic cnt_load;
    logic cnt_dec;
    logic cnt_last;

    div_step_if step_bus ();

    div_control u_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .busy_o     (busy_o),
        .ready_o    (ready_o),
        .cnt_load_o (cnt_load),
        .cnt_dec_o  (cnt_dec),
        .cnt_last_i (cnt_last),
        .step_bus   (step_bus.ctrl)
    );

    div_iter_counter u_counter (
        .clk    (clk),
        .rst_n  (rst_n),
        .load_i (cnt_load),
        .dec_i  (cnt_dec),
        .last_o (cnt_last)
    );

    div_datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .dividend_i (dividend_i),
        .divisor_i  (divisor_i),
        .op_i       (op_i),
        .result_o   (result_o),
        .step_bus   (step_bus.dp)
    );

endmodule

`default_nettype wire

//--- testbench/div_unit_properties.sv
// ----------------------------------------
// Divide controller assertions
// ready pulse, busy level and latency
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_unit_properties (
    input wire                           clk,
    input wire                           rst_n,
    input wire                           start_i,
    input wire                           busy_i,
    input wire                           ready_i,
    input wire                           cnt_load_i,
    input wire                           capture_i,
    input wire                           setup_i,
    input wire div_ctrl_pkg::div_state_e state_i
);

    import div_ctrl_pkg::*;

    // setup edge, then the loop edges and the finish edge
    localparam int LONG_HOLD = `DIV_ITERS + 1;

    int unsigned fail_count = 0; // failed assertions so far

    a_ready_single: assert property (@(posedge clk) disable iff (!rst_n)
        ready_i |=> !ready_i)
    else begin
        $error("ready_o stayed high for more than one cycle");
        fail_count++;
    end

    a_ready_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(ready_i && busy_i))
    else begin
        $error("ready_o and busy_o high together");
        fail_count++;
    end

    a_busy_state: assert property (@(posedge clk) disable iff (!rst_n)
        busy_i == (state_i != S_IDLE))
    else begin
        $error("busy_o does not match the controller state");
        fail_count++;
    end

    // full loop, start held throughout
    a_latency_loop: assert property (@(posedge clk) disable iff (!rst_n)
        capture_i ##1 cnt_load_i ##1 (start_i && !ready_i) [*LONG_HOLD] |=> ready_i)
    else begin
        $error("ready_o missing 34 cycles after capture");
        fail_count++;
    end

    a_latency_zero: assert property (@(posedge clk) disable iff (!rst_n)
        capture_i ##1 (setup_i && !cnt_load_i) ##1 start_i |=> ready_i)
    else begin
        $error("ready_o missing 2 cycles after a zero divisor capture");
        fail_count++;
    end

endmodule

bind div_control div_unit_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start_i),
    .busy_i     (busy_o),
    .ready_i    (ready_o),
    .cnt_load_i (cnt_load_o),
    .capture_i  (do_capture),
    .setup_i    (do_setup),
    .state_i    (state_q)
);

`default_nettype wire

//--- testbench/div_unit_tb.sv
// ----------------------------------------
// Divide unit testbench
// directed tests against a reference
// model of the M-extension divide rules
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_unit_tb;

    import div_op_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_OPS    = 44;             // operations over all tests
    localparam int OP_CYCLES  = `DIV_ITERS + 8; // one op plus idle gap, rounded up
    localparam int READY_WAIT = 2 * OP_CYCLES;

    logic      clk;
    logic      rst_n;
    logic      start_i;
    div_op_e   op_i;
    div_word_t dividend_i;
    div_word_t divisor_i;
    div_word_t result_o;
    logic      ready_o;
    logic      busy_o;

    int unsigned check_count;
    int unsigned error_count;
    logic [31:0] lcg_state;

    div_unit u_div_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .op_i       (op_i),
        .dividend_i (dividend_i),
        .divisor_i  (divisor_i),
        .result_o   (result_o),
        .ready_o    (ready_o),
        .busy_o     (busy_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // truncating division, remainder keeps the dividend sign
    function automatic div_word_t expected_result(div_op_e op, div_word_t a, div_word_t b);
        logic signed [`DIV_XLEN-1:0] sa;
        logic signed [`DIV_XLEN-1:0] sb;
        logic                        ovf;
        sa  = a;
        sb  = b;
        ovf = (a == {1'b1, {(`DIV_XLEN-1){1'b0}}}) && (b == '1);
        if (b == '0) begin
            if (op == OP_DIV || op == OP_DIVU) begin
                return '1;
            end
            return a;
        end
        case (op)
            OP_DIVU: return a / b;
            OP_REMU: return a % b;
            OP_DIV: begin
                if (ovf) begin
                    return a; // most negative value comes back unchanged
                end
                return div_word_t'(sa / sb);
            end
            OP_REM: begin
                if (ovf) begin
                    return '0;
                end
                return div_word_t'(sa % sb);
            end
            default: return '0;
        endcase
    endfunction

    // holds start_i until ready_o, cycles counted from the capture edge
    task automatic run_op(input div_op_e op, input div_word_t a, input div_word_t b,
                          output div_word_t res, output int cycles, output logic busy_drop);
        @(negedge clk);
        op_i       = op;
        dividend_i = a;
        divisor_i  = b;
        start_i    = 1'b1;
        @(posedge clk); // capture edge
        cycles    = 0;
        busy_drop = 1'b0;
        @(negedge clk);
        while (!ready_o && cycles < READY_WAIT) begin
            busy_drop = busy_drop | !busy_o; // busy must stay up until ready
            @(negedge clk);
            cycles++;
        end
        res     = result_o;
        start_i = 1'b0;
    endtask

    task automatic check_op(input div_op_e op, input div_word_t a, input div_word_t b);
        div_word_t res;
        div_word_t exp_res;
        int        cycles;
        int        exp_cycles;
        logic      busy_drop;
        exp_res    = expected_result(op, a, b);
        exp_cycles = (b == '0) ? 2 : `DIV_ITERS + 2;
        run_op(op, a, b, res, cycles, busy_drop);
        check_count += 3;
        if (!ready_o) begin
            error_count++;
            $display("%s %h / %h: no ready_o pulse within %0d cycles",
                     op.name(), a, b, READY_WAIT);
        end else begin
            if (res !== exp_res) begin
                error_count++;
                $display("MISMATCH result_o %s %h / %h: got %h expected %h",
                         op.name(), a, b, res, exp_res);
            end
            if (cycles != exp_cycles) begin
                error_count++;
                $display("MISMATCH ready_o latency %s %h / %h: got %h expected %h",
                         op.name(), a, b, cycles, exp_cycles);
            end
            if (busy_drop) begin
                error_count++;
                $display("MISMATCH busy_o during %s %h / %h: got 0 expected 1",
                         op.name(), a, b);
            end
        end
    endtask

    task automatic report_test(input string name, input int unsigned errors_before);
        $display("[%s] done, %0d errors", name, error_count - errors_before);
    endtask

    task automatic test_reset_state();
        int unsigned errs;
        errs = error_count;
        check_count += 3;
        if (busy_o !== 1'b0) begin
            error_count++;
            $display("MISMATCH busy_o after reset: got %h expected 0", busy_o);
        end
        if (ready_o !== 1'b0) begin
            error_count++;
            $display("MISMATCH ready_o after reset: got %h expected 0", ready_o);
        end
        if (result_o !== '0) begin
            error_count++;
            $display("MISMATCH result_o after reset: got %h expected 0", result_o);
        end
        // back to back, start_i low for one cycle in between
        check_op(OP_DIVU, 32'd100, 32'd7);
        check_op(OP_REMU, 32'd100, 32'd7);
        check_op(OP_DIV, -32'sd100, 32'd7);
        report_test("reset", errs);
    endtask

    task automatic test_unsigned();
        int unsigned errs;
        div_word_t   a;
        div_word_t   b;
        logic [31:0] r;
        errs = error_count;
        check_op(OP_DIVU, 32'hFFFF_FFFF, 32'd1);
        check_op(OP_REMU, 32'hFFFF_FFFF, 32'd1);
        check_op(OP_DIVU, 32'd12345678, 32'd1000);
        check_op(OP_REMU, 32'd12345678, 32'd1000);
        check_op(OP_DIVU, 32'd5, 32'hF000_0000);
        check_op(OP_REMU, 32'd5, 32'hF000_0000);
        for (int i = 0; i < 5; i++) begin
            a = next_rand();
            r = next_rand();
            b = next_rand() >> r[4:0]; // spread the divisor sizes
            check_op(OP_DIVU, a, b);
            check_op(OP_REMU, a, b);
        end
        report_test("unsigned", errs);
    endtask

    task automatic test_signed();
        int unsigned errs;
        div_word_t   a;
        div_word_t   b;
        logic [31:0] r;
        errs = error_count;
        for (int i = 0; i < 4; i++) begin
            a = i[0] ? -32'sd1000 : 32'sd1000;
            b = i[1] ? -32'sd7 : 32'sd7;
            check_op(OP_DIV, a, b);
            check_op(OP_REM, a, b);
        end
        for (int i = 0; i < 4; i++) begin
            a = next_rand();
            r = next_rand();
            b = next_rand() >> r[4:0];
            if (r[5]) begin
                b = -b;
            end
            check_op(OP_DIV, a, b);
            check_op(OP_REM, a, b);
        end
        report_test("signed", errs);
    endtask

    task automatic test_div_zero();
        int unsigned errs;
        errs = error_count;
        check_op(OP_DIV, 32'hDEAD_BEEF, 32'd0);
        check_op(OP_DIVU, 32'd42, 32'd0);
        check_op(OP_REM, 32'hDEAD_BEEF, 32'd0);
        check_op(OP_REMU, 32'd42, 32'd0);
        report_test("div_zero", errs);
    endtask

    task automatic test_overflow();
        int unsigned errs;
        errs = error_count;
        check_op(OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF);
        check_op(OP_REM, 32'h8000_0000, 32'hFFFF_FFFF);
        report_test("overflow", errs);
    endtask

    task automatic test_abort();
        int unsigned errs;
        div_word_t   held;
        logic        saw_ready;
        errs = error_count;
        check_op(OP_DIVU, 32'd999, 32'd10); // known result to hold on to
        held = expected_result(OP_DIVU, 32'd999, 32'd10);
        @(negedge clk);
        op_i       = OP_DIV;
        dividend_i = -32'sd5000;
        divisor_i  = 32'd3;
        start_i    = 1'b1;
        repeat (10) @(negedge clk); // well inside the loop
        start_i = 1'b0;
        @(negedge clk);
        saw_ready = ready_o;
        check_count += 3;
        if (busy_o !== 1'b0) begin
            error_count++;
            $display("MISMATCH busy_o after abort: got %h expected 0", busy_o);
        end
        repeat (OP_CYCLES) begin
            @(negedge clk);
            saw_ready = saw_ready | ready_o;
        end
        if (saw_ready) begin
            error_count++;
            $display("ready_o pulsed after the operation was aborted");
        end
        if (result_o !== held) begin
            error_count++;
            $display("MISMATCH result_o after abort: got %h expected %h", result_o, held);
        end
        check_op(OP_REM, -32'sd12345, 32'd100);
        report_test("abort", errs);
    endtask

    initial begin
        int unsigned assert_fails;
        clk         = 1'b0;
        rst_n       = 1'b0;
        start_i     = 1'b0;
        op_i        = OP_DIVU;
        dividend_i  = '0;
        divisor_i   = '0;
        check_count = 0;
        error_count = 0;
        lcg_state   = 32'd25;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_unsigned();
        test_signed();
        test_div_zero();
        test_overflow();
        test_abort();

        assert_fails = u_div_unit.u_control.u_props.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog sized from the operation count
    initial begin
        #(NUM_OPS * OP_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD);
        $display("watchdog: simulation did not finish within the time limit");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/div_op_pkg.sv
design/div_ctrl_pkg.sv
design/div_step_if.sv
design/div_iter_counter.sv
design/div_datapath.sv
design/div_control.sv
design/div_unit.sv
testbench/div_unit_properties.sv
testbench/div_unit_tb.sv

//--- Bender.yml
package:
  name: div_unit

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/div_op_pkg.sv
      - design/div_ctrl_pkg.sv
      - design/div_step_if.sv
      - design/div_iter_counter.sv
      - design/div_datapath.sv
      - design/div_control.sv
      - design/div_unit.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/div_unit_properties.sv
      - testbench/div_unit_tb.sv
